/* Bender.yml */
package:
  name: channel_adder

sources:
  # Package first, the RTL imports it
  - hw/chan_sum_pkg.sv

  # Leaf modules before the top level
  - hw/plane_delay_line.sv
  - hw/plane_tap_chain.sv
  - hw/plane_counter.sv
  - hw/pairwise_adder_tree.sv
  - hw/channel_adder_top.sv

  # Testbench, top module channel_adder_tb
  - target: simulation
    files:
      - testbench/channel_adder_tb.sv

export_include_dirs: []

dependencies: {}

/* channel_adder_top.f */
hw/chan_sum_pkg.sv
hw/plane_delay_line.sv
hw/plane_tap_chain.sv
hw/plane_counter.sv
hw/pairwise_adder_tree.sv
hw/channel_adder_top.sv
testbench/channel_adder_tb.sv

/* hw/chan_sum_pkg.sv */
package chan_sum_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // One channel's partial result from the per-channel convolution
  localparam int PIXEL_W = 16;

  // Headroom for up to 256 channels
  localparam int GUARD_W = 8;

  // Width of a partial or final channel sum
  localparam int SUM_W = PIXEL_W + GUARD_W;

  ////////////////////
  // Vector types
  ////////////////////

  typedef logic signed [PIXEL_W-1:0] pixel_t;
  typedef logic signed [SUM_W-1:0]   sum_t;

  ////////////////////
  // Stream beats
  ////////////////////

  // Input stream format
  typedef struct packed {
    logic   valid;
    pixel_t pixel;
  } pixel_beat_t;

  // Output stream format, also used between adder tree levels
  typedef struct packed {
    logic valid;
    sum_t sum;
  } sum_beat_t;

endpackage

/* hw/channel_adder_top.sv */
`timescale 1ns/10ps

module channel_adder_top
  import chan_sum_pkg::*;
#(
  parameter int IMAGE_SIZE  = 16,
  // Must be a power of two
  parameter int CHANNEL_NUM = 8
) (
  input  logic        clk,
  input  logic        reset,
  input  pixel_beat_t in_beat,
  output sum_beat_t   out_beat
);

  pixel_t [CHANNEL_NUM-1:0] taps;
  logic                     group_done;

  ////////////////////
  // Channel alignment
  ////////////////////

  plane_tap_chain #(
    .IMAGE_SIZE (IMAGE_SIZE),
    .CHANNEL_NUM(CHANNEL_NUM)
  ) u_plane_tap_chain (
    .clk    (clk),
    .reset  (reset),
    .in_beat(in_beat),
    .taps   (taps)
  );

  // Runs beside the chain on the same strobes
  plane_counter #(
    .IMAGE_SIZE (IMAGE_SIZE),
    .CHANNEL_NUM(CHANNEL_NUM)
  ) u_plane_counter (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (in_beat),
    .group_done(group_done)
  );

  ////////////////////
  // Summation
  ////////////////////

  // Sum appears LEVELS cycles after the completing beat
  pairwise_adder_tree #(
    .CHANNEL_NUM(CHANNEL_NUM)
  ) u_pairwise_adder_tree (
    .clk     (clk),
    .reset   (reset),
    .start   (group_done),
    .taps    (taps),
    .out_beat(out_beat)
  );

endmodule

/* hw/pairwise_adder_tree.sv */
`timescale 1ns/10ps

module pairwise_adder_tree
  import chan_sum_pkg::*;
#(
  parameter int CHANNEL_NUM = 8
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  pixel_t [CHANNEL_NUM-1:0] taps,
  output sum_beat_t                out_beat
);

  // One register stage per level
  localparam int LEVELS = $clog2(CHANNEL_NUM);

  ////////////////////
  // Tree levels
  ////////////////////

  // Level 0 is the widened taps, level LEVELS is the final sum
  for (genvar l = 0; l <= LEVELS; l++) begin : g_lvl
    localparam int N = CHANNEL_NUM >> l;

    sum_beat_t node [N];

    if (l == 0) begin : g_leaf
      // Sign extend each tap into a sum
      always_comb begin
        for (int i = 0; i < N; i++) begin
          node[i].valid = start;
          node[i].sum   = sum_t'(taps[i]);
        end
      end
    end else begin : g_add
      // Entry i pairs with entry i plus N of the level below
      always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
          if (reset) begin
            node[i].valid <= 1'b0;
          end else begin
            node[i].valid <= g_lvl[l-1].node[i].valid & g_lvl[l-1].node[i+N].valid;
          end

          // Payload loads on an incoming beat only
          if (g_lvl[l-1].node[i].valid) begin
            node[i].sum <= g_lvl[l-1].node[i].sum + g_lvl[l-1].node[i+N].sum;
          end
        end
      end
    end
  end

  ////////////////////
  // Output
  ////////////////////

  assign out_beat = g_lvl[LEVELS].node[0];

endmodule

/* hw/plane_counter.sv */
`timescale 1ns/10ps

module plane_counter
  import chan_sum_pkg::*;
#(
  parameter int IMAGE_SIZE  = 16,
  parameter int CHANNEL_NUM = 8
) (
  input  logic        clk,
  input  logic        reset,
  input  pixel_beat_t in_beat,
  output logic        group_done
);

  ////////////////////
  // Index widths
  ////////////////////

  // At least one bit even for a single pixel or a single plane
  localparam int PIX_IDX_W   = (IMAGE_SIZE > 1) ? $clog2(IMAGE_SIZE) : 1;
  localparam int PLANE_IDX_W = (CHANNEL_NUM > 1) ? $clog2(CHANNEL_NUM) : 1;

  typedef logic [PIX_IDX_W-1:0]   pix_idx_t;
  typedef logic [PLANE_IDX_W-1:0] plane_idx_t;

  localparam pix_idx_t   LAST_PIX   = pix_idx_t'(IMAGE_SIZE - 1);
  localparam plane_idx_t LAST_PLANE = plane_idx_t'(CHANNEL_NUM - 1);

  ////////////////////
  // Counters
  ////////////////////

  pix_idx_t   pix_idx;
  plane_idx_t plane_idx;
  logic       last_pix;
  logic       last_plane;

  assign last_pix   = (pix_idx == LAST_PIX);
  assign last_plane = (plane_idx == LAST_PLANE);

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_idx   <= '0;
      plane_idx <= '0;
    end else if (in_beat.valid) begin
      if (last_pix) begin
        pix_idx <= '0;
        // Plane rank moves on at the end of each plane
        if (last_plane) begin
          plane_idx <= '0;
        end else begin
          plane_idx <= plane_idx + 1'b1;
        end
      end else begin
        pix_idx <= pix_idx + 1'b1;
      end
    end
  end

  ////////////////////
  // Group flag
  ////////////////////

  // During the final plane the tap chain holds every channel of the position
  assign group_done = in_beat.valid & last_plane;

endmodule

/* hw/plane_delay_line.sv */
`timescale 1ns/10ps

module plane_delay_line
  import chan_sum_pkg::*;
#(
  parameter int IMAGE_SIZE = 16
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   valid,
  input  pixel_t data_in,
  output pixel_t data_out
);

  ////////////////////
  // Plane store
  ////////////////////

  // Entry 0 is the newest pixel
  // Entry IMAGE_SIZE-1 is the pixel written one plane of strobes ago
  pixel_t store [IMAGE_SIZE];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < IMAGE_SIZE; i++) begin
        store[i] <= '0;
      end
    end else if (valid) begin
      // Shift only on a strobe so that gaps keep the alignment
      store[0] <= data_in;
      for (int i = 1; i < IMAGE_SIZE; i++) begin
        store[i] <= store[i-1];
      end
    end
  end

  ////////////////////
  // Output
  ////////////////////

  // Read straight from storage
  // Valid in the same cycle as the strobe that presents data_in
  assign data_out = store[IMAGE_SIZE-1];

endmodule

/* hw/plane_tap_chain.sv */
`timescale 1ns/10ps

module plane_tap_chain
  import chan_sum_pkg::*;
#(
  parameter int IMAGE_SIZE  = 16,
  parameter int CHANNEL_NUM = 8
) (
  input  logic                     clk,
  input  logic                     reset,
  input  pixel_beat_t              in_beat,
  output pixel_t [CHANNEL_NUM-1:0] taps
);

  ////////////////////
  // Delay cascade
  ////////////////////

  // chain[k] holds the same position k planes back
  pixel_t chain [CHANNEL_NUM];

  // Live input is tap 0
  assign chain[0] = in_beat.pixel;

  for (genvar k = 1; k < CHANNEL_NUM; k++) begin : g_line
    // Every stage advances on the input strobe
    plane_delay_line #(
      .IMAGE_SIZE(IMAGE_SIZE)
    ) u_plane_delay_line (
      .clk     (clk),
      .reset   (reset),
      .valid   (in_beat.valid),
      .data_in (chain[k-1]),
      .data_out(chain[k])
    );
  end

  ////////////////////
  // Tap outputs
  ////////////////////

  always_comb begin
    for (int k = 0; k < CHANNEL_NUM; k++) begin
      taps[k] = chain[k];
    end
  end

endmodule

/* testbench/channel_adder_tb.sv */
`timescale 1ns/10ps

module channel_adder_tb
  import chan_sum_pkg::*;
;

  localparam int IMAGE_SIZE   = 16;
  localparam int CHANNEL_NUM  = 8;
  localparam int LEVELS       = $clog2(CHANNEL_NUM);
  localparam int GROUP_BEATS  = CHANNEL_NUM * IMAGE_SIZE;
  localparam int RESET_CYCLES = 3;

  // Reset lands inside plane 3 of the aborted group
  localparam int PARTIAL_BEATS = 3 * IMAGE_SIZE + 5;
  localparam int NUM_GROUPS    = 7;

  // Six full groups plus the aborted one at roughly 70 percent valid
  localparam int STIM_BEATS     = 6 * GROUP_BEATS + PARTIAL_BEATS;
  localparam int STIM_CYCLES    = STIM_BEATS * 10 / 7 + 2 * RESET_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  localparam int MODE_RANDOM = 0;
  localparam int MODE_MAX    = 1;
  localparam int MODE_MIN    = 2;

  logic        clk;
  logic        reset;
  pixel_beat_t in_beat;
  sum_beat_t   out_beat;

  int          cycle;
  int          out_count;
  logic        entry_due;

  pixel_t pix_mem [NUM_GROUPS][CHANNEL_NUM][IMAGE_SIZE];

  // Expected results in arrival order
  sum_t exp_sum_q [$];
  int   exp_due_q [$];
  int   exp_pos_q [$];

  channel_adder_top #(
    .IMAGE_SIZE (IMAGE_SIZE),
    .CHANNEL_NUM(CHANNEL_NUM)
  ) u_channel_adder_top (
    .clk     (clk),
    .reset   (reset),
    .in_beat (in_beat),
    .out_beat(out_beat)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Signed sum of one position over all planes of a group
  function automatic sum_t ref_sum(input int g, input int pos);
    sum_t acc;
    acc = '0;
    for (int p = 0; p < CHANNEL_NUM; p++) begin
      acc = acc + sum_t'(pix_mem[g][p][pos]);
    end
    return acc;
  endfunction

  function automatic pixel_t pick_pixel(input int mode);
    if (mode == MODE_MAX) begin
      return pixel_t'({1'b0, {(PIXEL_W-1){1'b1}}});
    end else if (mode == MODE_MIN) begin
      return pixel_t'({1'b1, {(PIXEL_W-1){1'b0}}});
    end
    return pixel_t'($urandom);
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic idle_cycle();
    pixel_beat_t beat;
    @(posedge clk);
    beat.valid = 1'b0;
    beat.pixel = pixel_t'($urandom);
    in_beat <= beat;
  endtask

  task automatic send_pixel(input int g, input int plane, input int pos,
                            input pixel_t px, input bit gaps);
    pixel_beat_t beat;
    // About three cycles in ten stay idle
    if (gaps) begin
      while (($urandom % 10) >= 7) begin
        idle_cycle();
      end
    end
    @(posedge clk);
    beat.valid = 1'b1;
    beat.pixel = px;
    in_beat <= beat;
    pix_mem[g][plane][pos] = px;
    // Final plane completes the position
    if (plane == CHANNEL_NUM - 1) begin
      exp_sum_q.push_back(ref_sum(g, pos));
      exp_due_q.push_back(cycle + LEVELS);
      exp_pos_q.push_back(pos);
    end
  endtask

  task automatic send_group(input int g, input int mode, input bit gaps, input int n_beats);
    for (int i = 0; i < n_beats; i++) begin
      send_pixel(g, i / IMAGE_SIZE, i % IMAGE_SIZE, pick_pixel(mode), gaps);
    end
  endtask

  task automatic hold_reset(input int n);
    @(posedge clk);
    reset <= 1'b1;
    in_beat <= '0;
    repeat (n) @(posedge clk);
    reset <= 1'b0;
  endtask

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: out_beat.valid is %b, expected %b in cycle %0d",
               $time, got, exp, cycle);
      $display("RESULT: FAIL");
      $fatal(1, "Output valid check failed");
    end
  endtask

  task automatic check_sum(input sum_t got, input sum_t exp, input int pos);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: position %0d sum is %0d, expected %0d",
               $time, pos, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Output sum check failed");
    end
  endtask

  // Outputs are stable on the falling edge
  always @(negedge clk) begin
    entry_due = (exp_due_q.size() > 0) && (exp_due_q[0] == cycle);
    check_valid(out_beat.valid, entry_due);
    if (entry_due) begin
      check_sum(out_beat.sum, exp_sum_q[0], exp_pos_q[0]);
      void'(exp_sum_q.pop_front());
      void'(exp_due_q.pop_front());
      void'(exp_pos_q.pop_front());
      out_count = out_count + 1;
    end
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $fatal(1, "Timeout");
    end
    cycle <= cycle + 1;
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(48));
    cycle     = 0;
    out_count = 0;
    reset     = 1'b1;
    in_beat   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    send_group(0, MODE_RANDOM, 1'b1, GROUP_BEATS);
    send_group(1, MODE_RANDOM, 1'b1, GROUP_BEATS);
    // Extreme values back to back
    send_group(2, MODE_MAX, 1'b0, GROUP_BEATS);
    send_group(3, MODE_MIN, 1'b0, GROUP_BEATS);

    // Aborted group is never summed
    send_group(4, MODE_RANDOM, 1'b1, PARTIAL_BEATS);
    hold_reset(RESET_CYCLES);
    send_group(5, MODE_RANDOM, 1'b1, GROUP_BEATS);
    send_group(6, MODE_RANDOM, 1'b1, GROUP_BEATS);
    idle_cycle();

    while (exp_due_q.size() != 0) begin
      @(posedge clk);
    end
    // Watch for stray outputs after the last sum
    repeat (LEVELS + 2) @(posedge clk);

    if (exp_due_q.size() == 0 && out_count == 6 * IMAGE_SIZE) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Received %0d sums where %0d were expected", out_count, 6 * IMAGE_SIZE);
      $display("RESULT: FAIL");
      $fatal(1, "Output count check failed");
    end
  end

endmodule
